//--- src/tcb_pkg.sv
package tcb_pkg;

////////////////////////////////////////
// bus geometry
////////////////////////////////////////

  // data bus, fixed at 32 bits
  localparam int unsigned tcb_data_width = 32;
  localparam int unsigned tcb_byte_count = 4;
  localparam int unsigned tcb_byte_width = tcb_data_width / tcb_byte_count;

  // byte address, split into word address and lane offset
  localparam int unsigned tcb_addr_width      = 12;
  localparam int unsigned tcb_off_width       = $clog2(tcb_byte_count);
  localparam int unsigned tcb_word_addr_width = tcb_addr_width - tcb_off_width;

  // on-chip memory size in words
  localparam int unsigned tcb_mem_depth = 1024;

////////////////////////////////////////
// encodings
////////////////////////////////////////

  // access size, log2 of the byte count
  // encoding 3 is unused
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } tcb_size_e;

  // byte order of the request data
  typedef enum logic {
    endian_little = 1'b0,
    endian_big    = 1'b1
  } tcb_endian_e;

  // response status
  typedef enum logic {
    status_ok         = 1'b0,
    status_misaligned = 1'b1
  } tcb_status_e;

////////////////////////////////////////
// transfer structs
////////////////////////////////////////

  // reference mode request, data right-aligned
  typedef struct packed {
    logic                      wen;
    logic [tcb_addr_width-1:0] adr;
    tcb_size_e                 siz;
    tcb_endian_e               ndn;
    logic [tcb_data_width-1:0] wdt;
  } tcb_req_t;

  // memory mode request, data on address lanes
  typedef struct packed {
    logic                           wen;
    logic [tcb_word_addr_width-1:0] adr;
    logic [tcb_byte_count-1:0]      ben;
    logic [tcb_data_width-1:0]      wdt;
  } tcb_mem_req_t;

  // response back to the manager
  typedef struct packed {
    logic [tcb_data_width-1:0] rdt;
    tcb_status_e               sts;
  } tcb_rsp_t;

  // index of the last byte within a sized field
  function automatic logic [tcb_off_width-1:0] tcb_size_last(tcb_size_e siz);
    case (siz)
      size_half: return 2'd1;
      size_word: return 2'd3;
      default:   return 2'd0;
    endcase
  endfunction

endpackage

//--- src/tcb_align_checker.sv
`timescale 1ns/1ps

module tcb_align_checker (
  // clock and valid used by the assertion only
  input  logic                                clk,
  input  logic                                vld,
  // request attributes
  input  tcb_pkg::tcb_size_e                  siz,
  input  logic [tcb_pkg::tcb_off_width-1:0]   adr,
  // misaligned access flag
  output logic                                mal
);

////////////////////////////////////////
// alignment decision
////////////////////////////////////////

  // same decoding for reads and writes
  always_comb begin
    case (siz)
      // single byte fits any lane
      tcb_pkg::size_byte: mal = 1'b0;
      // half needs an even address
      tcb_pkg::size_half: mal = adr[0];
      // word needs both low bits clear
      tcb_pkg::size_word: mal = |adr[1:0];
      // unused encoding never reaches memory
      default:            mal = 1'b1;
    endcase
  end

////////////////////////////////////////
// checks
////////////////////////////////////////

  // manager must not issue the unused size code
  a_siz_legal: assert property (
    @(posedge clk) vld |-> (siz inside {tcb_pkg::size_byte,
                                        tcb_pkg::size_half,
                                        tcb_pkg::size_word})
  ) else $error("tcb_align_checker: unused size encoding %0d", siz);

endmodule

//--- src/tcb_lane_mapper.sv
`timescale 1ns/1ps

module tcb_lane_mapper (
  // reference mode request from the manager
  input  tcb_pkg::tcb_req_t     req,
  // memory mode request toward the array
  output tcb_pkg::tcb_mem_req_t mem_req
);

////////////////////////////////////////
// local signals
////////////////////////////////////////

  // lane offset within the word
  logic [tcb_pkg::tcb_off_width-1:0] off;
  // last byte index of the sized field
  logic [tcb_pkg::tcb_off_width-1:0] last;

  // size mask before shifting to the offset
  logic [tcb_pkg::tcb_byte_count-1:0] siz_mask;

  // write data viewed as byte lanes
  logic [tcb_pkg::tcb_byte_count-1:0][tcb_pkg::tcb_byte_width-1:0] req_wdt;
  logic [tcb_pkg::tcb_byte_count-1:0][tcb_pkg::tcb_byte_width-1:0] mem_wdt;

  // lane position relative to the offset and the byte it takes
  logic [tcb_pkg::tcb_off_width-1:0] rel [tcb_pkg::tcb_byte_count];
  logic [tcb_pkg::tcb_off_width-1:0] sel [tcb_pkg::tcb_byte_count];

  assign off     = req.adr[tcb_pkg::tcb_off_width-1:0];
  assign last    = tcb_pkg::tcb_size_last(req.siz);
  assign req_wdt = req.wdt;

////////////////////////////////////////
// byte enables
////////////////////////////////////////

  // low bytes covered by the size
  always_comb begin
    for (int i = 0; i < tcb_pkg::tcb_byte_count; i++) begin
      siz_mask[i] = (i[tcb_pkg::tcb_off_width-1:0] <= last);
    end
  end

  // shifted up to the addressed lanes
  // overflow only on misaligned accesses that the top gates off
  assign mem_req.ben = siz_mask << off;

////////////////////////////////////////
// write data steering
////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < tcb_pkg::tcb_byte_count; i++) begin
      // distance of lane i above the offset modulo 4
      rel[i] = i[tcb_pkg::tcb_off_width-1:0] - off;
      // little endian puts byte k on lane off+k
      // big endian reverses the bytes within the field
      if (req.ndn == tcb_pkg::endian_big) begin
        sel[i] = last - rel[i];
      end else begin
        sel[i] = rel[i];
      end
      mem_wdt[i] = req_wdt[sel[i]];
    end
  end

  // unused lanes carry don't-care bytes that ben masks
  assign mem_req.wdt = mem_wdt;

////////////////////////////////////////
// command and address
////////////////////////////////////////

  assign mem_req.wen = req.wen;

  // word address without the offset bits
  assign mem_req.adr = req.adr[tcb_pkg::tcb_addr_width-1:tcb_pkg::tcb_off_width];

endmodule

//--- src/tcb_mem.sv
`timescale 1ns/1ps

module tcb_mem (
  input  logic                                clk,
  input  logic                                reset,
  // access enable, already qualified by handshake and alignment
  input  logic                                en,
  input  tcb_pkg::tcb_mem_req_t               mem_req,
  // read data, one cycle after the access
  output logic [tcb_pkg::tcb_data_width-1:0]  rdt
);

////////////////////////////////////////
// storage
////////////////////////////////////////

  // word array
  logic [tcb_pkg::tcb_data_width-1:0] mem [tcb_pkg::tcb_mem_depth];

  // write and read strobes
  logic wr;
  logic rd;

  assign wr = en &  mem_req.wen;
  assign rd = en & ~mem_req.wen;

////////////////////////////////////////
// write port
////////////////////////////////////////

  // one byte per enabled lane
  always_ff @(posedge clk) begin
    if (wr) begin
      for (int b = 0; b < tcb_pkg::tcb_byte_count; b++) begin
        if (mem_req.ben[b]) begin
          mem[mem_req.adr][b*tcb_pkg::tcb_byte_width +: tcb_pkg::tcb_byte_width]
            <= mem_req.wdt[b*tcb_pkg::tcb_byte_width +: tcb_pkg::tcb_byte_width];
        end
      end
    end
  end

////////////////////////////////////////
// read port
////////////////////////////////////////

  // full word always, lane selection is done in the response stage
  always_ff @(posedge clk) begin
    if (reset) begin
      rdt <= '0;
    end else if (rd) begin
      rdt <= mem[mem_req.adr];
    end
  end

endmodule

//--- src/tcb_rsp_combiner.sv
`timescale 1ns/1ps

module tcb_rsp_combiner (
  input  logic                                clk,
  input  logic                                reset,
  // handshake fired this cycle
  input  logic                                acc,
  // request attributes sampled on acc
  input  tcb_pkg::tcb_req_t                   req,
  input  logic                                mal,
  // memory read data valid the cycle after acc
  input  logic [tcb_pkg::tcb_data_width-1:0]  mem_rdt,
  // response toward the manager
  output logic                                rsp_vld,
  output tcb_pkg::tcb_rsp_t                   rsp
);

////////////////////////////////////////
// attribute pipeline
////////////////////////////////////////

  // response pending
  logic                              vld_q;
  // access attributes of the pending response
  logic                              wen_q;
  logic                              mal_q;
  tcb_pkg::tcb_size_e                siz_q;
  tcb_pkg::tcb_endian_e              ndn_q;
  logic [tcb_pkg::tcb_off_width-1:0] off_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= acc;
    end
  end

  // captured only on a transfer
  always_ff @(posedge clk) begin
    if (acc) begin
      wen_q <= req.wen;
      mal_q <= mal;
      siz_q <= req.siz;
      ndn_q <= req.ndn;
      off_q <= req.adr[tcb_pkg::tcb_off_width-1:0];
    end
  end

////////////////////////////////////////
// read data back to reference mode
////////////////////////////////////////

  logic [tcb_pkg::tcb_off_width-1:0] last;
  logic [tcb_pkg::tcb_off_width-1:0] lane [tcb_pkg::tcb_byte_count];

  logic [tcb_pkg::tcb_byte_count-1:0][tcb_pkg::tcb_byte_width-1:0] mem_lanes;
  logic [tcb_pkg::tcb_byte_count-1:0][tcb_pkg::tcb_byte_width-1:0] rdt_bytes;

  assign last      = tcb_pkg::tcb_size_last(siz_q);
  assign mem_lanes = mem_rdt;

  // inverse of the mapper steering
  always_comb begin
    for (int k = 0; k < tcb_pkg::tcb_byte_count; k++) begin
      // little endian takes byte k from lane off+k
      // big endian takes byte k from lane off+last-k
      if (ndn_q == tcb_pkg::endian_big) begin
        lane[k] = off_q + last - k[tcb_pkg::tcb_off_width-1:0];
      end else begin
        lane[k] = off_q + k[tcb_pkg::tcb_off_width-1:0];
      end
      // bytes beyond the size read as zero
      if (k[tcb_pkg::tcb_off_width-1:0] <= last) begin
        rdt_bytes[k] = mem_lanes[lane[k]];
      end else begin
        rdt_bytes[k] = '0;
      end
    end
  end

////////////////////////////////////////
// response
////////////////////////////////////////

  assign rsp_vld = vld_q;

  // writes and misaligned accesses return zero data
  assign rsp.rdt = (wen_q | mal_q) ? '0 : rdt_bytes;
  assign rsp.sts = mal_q ? tcb_pkg::status_misaligned : tcb_pkg::status_ok;

  // one response per transfer exactly one cycle later
  a_rsp_follows_acc: assert property (
    @(posedge clk) disable iff (reset) acc |=> rsp_vld
  ) else $error("tcb_rsp_combiner: missing response after transfer");

  a_no_spurious_rsp: assert property (
    @(posedge clk) disable iff (reset) !acc |=> !rsp_vld
  ) else $error("tcb_rsp_combiner: response without transfer");

endmodule

//--- src/tcb_subsystem.sv
`timescale 1ns/1ps

module tcb_subsystem (
  input  logic                clk,
  input  logic                reset,
  // manager request
  input  logic                vld,
  input  tcb_pkg::tcb_req_t   req,
  output logic                rdy,
  // response to the manager
  output logic                rsp_vld,
  output tcb_pkg::tcb_rsp_t   rsp
);

  // handshake and alignment
  logic                               acc;
  logic                               mal;
  logic                               mem_en;
  // memory side
  tcb_pkg::tcb_mem_req_t              mem_req;
  logic [tcb_pkg::tcb_data_width-1:0] mem_rdt;

  // memory never stalls, so ready follows reset release
  assign rdy    = ~reset;
  assign acc    = vld & rdy;
  // misaligned accesses never touch the array
  assign mem_en = acc & ~mal;

////////////////////////////////////////
// request path
////////////////////////////////////////

  tcb_align_checker tcb_align_checker_inst (
    .clk (clk),
    .vld (vld),
    .siz (req.siz),
    .adr (req.adr[tcb_pkg::tcb_off_width-1:0]),
    .mal (mal)
  );

  tcb_lane_mapper tcb_lane_mapper_inst (
    .req     (req),
    .mem_req (mem_req)
  );

  tcb_mem tcb_mem_inst (
    .clk     (clk),
    .reset   (reset),
    .en      (mem_en),
    .mem_req (mem_req),
    .rdt     (mem_rdt)
  );

////////////////////////////////////////
// response path
////////////////////////////////////////

  tcb_rsp_combiner tcb_rsp_combiner_inst (
    .clk     (clk),
    .reset   (reset),
    .acc     (acc),
    .req     (req),
    .mal     (mal),
    .mem_rdt (mem_rdt),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

endmodule

//--- tb/tcb_subsystem_tb.sv
`timescale 1ns/1ps

module tcb_subsystem_tb;

////////////////////////////////////////
// types and signals
////////////////////////////////////////

  // expected response, tagged with its test
  typedef struct packed {
    tcb_pkg::tcb_rsp_t rsp;
    logic [2:0]        tid;
  } exp_t;

  logic              clk;
  logic              reset;
  logic              vld;
  tcb_pkg::tcb_req_t req;
  logic              rdy;
  logic              rsp_vld;
  tcb_pkg::tcb_rsp_t rsp;

  // byte model of the memory, one entry per byte address
  logic [7:0] model_mem [1 << tcb_pkg::tcb_addr_width];

  // expected responses in issue order
  exp_t exp_q [$];
  int   rd_idx;
  // entry for the response due this cycle
  exp_t exp_now;
  logic exp_pend;

  integer seed            = 32'hbe4483b3;
  int     cycles          = 0;
  int     value_errors    = 0;
  int     protocol_errors = 0;

  tcb_subsystem tcb_subsystem_inst (
    .clk     (clk),
    .reset   (reset),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // tests need about 100 cycles, 400 leaves ample margin
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 400) begin
      $display("timeout: no end of test after %0d cycles", cycles);
      $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

////////////////////////////////////////
// response tracking
////////////////////////////////////////

  // pick the expected entry on every transfer
  always @(posedge clk) begin
    if (reset) begin
      rd_idx   <= 0;
      exp_pend <= 1'b0;
    end else begin
      exp_pend <= vld && rdy;
      if (vld && rdy) begin
        exp_now <= exp_q[rd_idx];
        rd_idx  <= rd_idx + 1;
      end
    end
  end

  // ready follows reset release
  a_rdy_high: assert property (@(posedge clk) !reset |-> rdy)
    else begin
      protocol_errors++;
      $display("rdy was low outside reset");
    end

  a_quiet_reset: assert property (@(posedge clk) reset |=> !rsp_vld)
    else begin
      protocol_errors++;
      $display("rsp_vld was high right after a reset cycle");
    end

  // exactly one cycle from transfer to response
  a_latency: assert property (@(posedge clk) disable iff (reset) (vld && rdy) |=> rsp_vld)
    else begin
      protocol_errors++;
      $display("no rsp_vld one cycle after a transfer");
    end

  a_no_extra: assert property (@(posedge clk) disable iff (reset) !(vld && rdy) |=> !rsp_vld)
    else begin
      protocol_errors++;
      $display("rsp_vld high without a transfer the cycle before");
    end

  a_rdt: assert property (@(posedge clk) disable iff (reset)
    exp_pend |-> rsp.rdt == exp_now.rsp.rdt)
    else begin
      value_errors++;
      $display("Fail %s: rdt expected %h actual %h", test_name($sampled(exp_now.tid)),
               $sampled(exp_now.rsp.rdt), $sampled(rsp.rdt));
    end

  a_sts: assert property (@(posedge clk) disable iff (reset)
    exp_pend |-> rsp.sts == exp_now.rsp.sts)
    else begin
      value_errors++;
      $display("Fail %s: sts expected %0d actual %0d", test_name($sampled(exp_now.tid)),
               $sampled(exp_now.rsp.sts), $sampled(rsp.sts));
    end

////////////////////////////////////////
// helpers
////////////////////////////////////////

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic string test_name(input logic [2:0] tid);
    case (tid)
      3'd1:    return "word_rw";
      3'd2:    return "le_sized";
      3'd3:    return "be_order";
      3'd4:    return "misaligned";
      3'd5:    return "back_to_back";
      default: return "reset";
    endcase
  endfunction

  // predict one access, updating the byte model on writes
  task automatic model_access(input logic wen, input logic [11:0] adr,
                              input tcb_pkg::tcb_size_e siz, input tcb_pkg::tcb_endian_e ndn,
                              input logic [31:0] wdt, output tcb_pkg::tcb_rsp_t r);
    int          n;
    int          src;
    logic [11:0] a;
    n     = 1 << siz;
    r.rdt = '0;
    r.sts = tcb_pkg::status_ok;
    if ((int'(adr) % n) != 0) begin
      // memory untouched, zero data
      r.sts = tcb_pkg::status_misaligned;
    end else begin
      for (int k = 0; k < n; k++) begin
        a = adr + 12'(k);
        // big endian puts the last data byte at the lowest address
        if (ndn == tcb_pkg::endian_big) begin
          src = n - 1 - k;
        end else begin
          src = k;
        end
        if (wen) begin
          model_mem[a] = wdt[8*src +: 8];
        end else begin
          r.rdt[8*src +: 8] = model_mem[a];
        end
      end
    end
  endtask

  // one request, held until the handshake fires
  task automatic issue(input logic wen, input logic [11:0] adr,
                       input tcb_pkg::tcb_size_e siz, input tcb_pkg::tcb_endian_e ndn,
                       input logic [31:0] wdt, input logic [2:0] tid);
    exp_t              e;
    tcb_pkg::tcb_rsp_t r;
    req.wen = wen;
    req.adr = adr;
    req.siz = siz;
    req.ndn = ndn;
    req.wdt = wdt;
    vld     = 1'b1;
    model_access(wen, adr, siz, ndn, wdt, r);
    e.rsp = r;
    e.tid = tid;
    exp_q.push_back(e);
    @(posedge clk);
    while (!rdy) begin
      @(posedge clk);
    end
    #1;
  endtask

  // idle until every response has been checked
  task automatic drain();
    vld = 1'b0;
    while (rd_idx != exp_q.size() || exp_pend) begin
      @(posedge clk);
      #1;
    end
  endtask

////////////////////////////////////////
// stimulus
////////////////////////////////////////

  initial begin
    logic [11:0]          adr;
    tcb_pkg::tcb_size_e   siz;
    tcb_pkg::tcb_endian_e ndn;
    clk   = 1'b0;
    reset = 1'b1;
    vld   = 1'b0;
    req   = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    // a few idle cycles, nothing may answer
    repeat (2) @(posedge clk);
    #1;

    // aligned words, write then read back
    for (int i = 0; i < 8; i++) begin
      issue(1'b1, 12'h100 + 12'(4*i), tcb_pkg::size_word, tcb_pkg::endian_little,
            rand_word(), 3'd1);
    end
    for (int i = 0; i < 8; i++) begin
      issue(1'b0, 12'h100 + 12'(4*i), tcb_pkg::size_word, tcb_pkg::endian_little, '0, 3'd1);
    end
    drain();

    // little endian bytes on a prefilled word
    issue(1'b1, 12'h200, tcb_pkg::size_word, tcb_pkg::endian_little, rand_word(), 3'd2);
    for (int off = 0; off < 4; off++) begin
      adr = 12'h200 + 12'(off);
      issue(1'b1, adr, tcb_pkg::size_byte, tcb_pkg::endian_little, rand_word(), 3'd2);
      issue(1'b0, 12'h200, tcb_pkg::size_word, tcb_pkg::endian_little, '0, 3'd2);
      issue(1'b0, adr, tcb_pkg::size_byte, tcb_pkg::endian_little, '0, 3'd2);
    end
    // little endian halves
    issue(1'b1, 12'h204, tcb_pkg::size_word, tcb_pkg::endian_little, rand_word(), 3'd2);
    for (int off = 0; off < 4; off += 2) begin
      adr = 12'h204 + 12'(off);
      issue(1'b1, adr, tcb_pkg::size_half, tcb_pkg::endian_little, rand_word(), 3'd2);
      issue(1'b0, 12'h204, tcb_pkg::size_word, tcb_pkg::endian_little, '0, 3'd2);
      issue(1'b0, adr, tcb_pkg::size_half, tcb_pkg::endian_little, '0, 3'd2);
    end
    drain();

    // big endian halves and a word, seen as little endian words
    issue(1'b1, 12'h300, tcb_pkg::size_word, tcb_pkg::endian_little, rand_word(), 3'd3);
    for (int off = 0; off < 4; off += 2) begin
      adr = 12'h300 + 12'(off);
      issue(1'b1, adr, tcb_pkg::size_half, tcb_pkg::endian_big, rand_word(), 3'd3);
      issue(1'b0, 12'h300, tcb_pkg::size_word, tcb_pkg::endian_little, '0, 3'd3);
      issue(1'b0, adr, tcb_pkg::size_half, tcb_pkg::endian_big, '0, 3'd3);
    end
    issue(1'b1, 12'h304, tcb_pkg::size_word, tcb_pkg::endian_big, rand_word(), 3'd3);
    issue(1'b0, 12'h304, tcb_pkg::size_word, tcb_pkg::endian_little, '0, 3'd3);
    issue(1'b0, 12'h304, tcb_pkg::size_word, tcb_pkg::endian_big, '0, 3'd3);
    drain();

    // misaligned words and halves, then aligned read of the same word
    for (int off = 1; off < 4; off++) begin
      adr = 12'h104 + 12'(off);
      issue(1'b1, adr, tcb_pkg::size_word, tcb_pkg::endian_little, rand_word(), 3'd4);
      issue(1'b0, adr, tcb_pkg::size_word, tcb_pkg::endian_big, '0, 3'd4);
      issue(1'b0, 12'h104, tcb_pkg::size_word, tcb_pkg::endian_little, '0, 3'd4);
    end
    for (int off = 1; off < 4; off += 2) begin
      adr = 12'h108 + 12'(off);
      issue(1'b1, adr, tcb_pkg::size_half, tcb_pkg::endian_big, rand_word(), 3'd4);
      issue(1'b0, adr, tcb_pkg::size_half, tcb_pkg::endian_little, '0, 3'd4);
      issue(1'b0, 12'h108, tcb_pkg::size_word, tcb_pkg::endian_little, '0, 3'd4);
    end
    drain();

    // one read per cycle, mixed size and byte order
    for (int i = 0; i < 16; i++) begin
      if (i % 2 == 1) begin
        siz = tcb_pkg::size_half;
      end else begin
        siz = tcb_pkg::size_word;
      end
      if ((i / 2) % 2 == 1) begin
        ndn = tcb_pkg::endian_big;
      end else begin
        ndn = tcb_pkg::endian_little;
      end
      adr = 12'h100 + 12'(4 * (i % 8));
      // upper half of the word on every other half read
      if (i % 4 == 1) begin
        adr = adr + 12'd2;
      end
      issue(1'b0, adr, siz, ndn, '0, 3'd5);
    end
    drain();

    $display("checks done: %0d value errors, %0d protocol errors",
             value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- compile.f
src/tcb_pkg.sv
src/tcb_align_checker.sv
src/tcb_lane_mapper.sv
src/tcb_mem.sv
src/tcb_rsp_combiner.sv
src/tcb_subsystem.sv
tb/tcb_subsystem_tb.sv

//--- Makefile
# Verilator build and run for the TCB subsystem testbench

SRCS := $(shell grep -v '^+' compile.f)
BIN  := obj_dir/Vtcb_subsystem_tb

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): compile.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module tcb_subsystem_tb -f compile.f

# fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
